// ==== tb.f ====
+incdir+.
coherence_pkg.sv
line_state_table.sv
coherence_ctrl.sv
bus_issue_slot.sv
icache_coherence.sv
icache_coherence_props.sv
tb_icache_coherence.sv

// ==== Makefile ====
# Verilator build and run for the instruction cache coherence controller

SIM_TOP   ?= tb_icache_coherence
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
SIM_ARGS  ?= +verilator+error+limit+100
LOG       ?= sim.log
PASS_TEXT ?= >>> PASS

SOURCES := $(shell grep -v '^+' $(FILELIST)) coherence_settings.svh
SIM_BIN := $(BUILD_DIR)/V$(SIM_TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(SIM_TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS) | tee $(LOG)
	@grep -q -- '$(PASS_TEXT)' $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb_icache_coherence.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "coherence_settings.svh"

module tb_icache_coherence;

  localparam int CLK_PERIOD = 20;
  localparam int NUM_TESTS  = 5;
  localparam int TAG_SHIFT  = `COH_OFFSET_BITS + `COH_INDEX_BITS;
  localparam int MEM_NODE   = `COH_NUM_NODES;

  logic                     clk;
  logic                     rst;
  coherence_pkg::addr_t     fetch_addr;
  logic                     miss_read;
  logic                     lookup;
  coherence_pkg::way_vec_t  hit_ways;
  coherence_pkg::way_vec_t  victim_ways;
  coherence_pkg::way_vec_t  snoop_hit_ways;
  coherence_pkg::line_t     bus_rdata;
  logic                     hit_resp;
  coherence_pkg::line_t     fill_data;
  logic                     fill_valid;
  coherence_pkg::req_msg_t  req_bus_msg;
  coherence_pkg::req_msg_t  req_bus_tx;
  logic                     req_bus_req;
  logic                     req_bus_busy;
  coherence_pkg::resp_msg_t resp_bus_msg;
  coherence_pkg::resp_msg_t resp_bus_tx;
  logic                     resp_bus_req;

  integer seed;
  int     errors;
  int     tests_run;
  int     failed_tests;
  int     test_start;

  icache_coherence #(.ID(0)) i_dut (.*);

  bind icache_coherence icache_coherence_props i_props (
    .clk          (clk),
    .rst          (rst),
    .req_bus_msg  (req_bus_msg),
    .req_bus_tx   (req_bus_tx),
    .req_bus_req  (req_bus_req),
    .req_bus_busy (req_bus_busy),
    .resp_bus_msg (resp_bus_msg),
    .resp_bus_tx  (resp_bus_tx),
    .resp_bus_req (resp_bus_req),
    .fill_valid   (fill_valid),
    .hit_resp     (hit_resp)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(NUM_TESTS * 200 * CLK_PERIOD);
    $display("Watchdog expired: the tests did not finish in time");
    $display(">>> FAIL");
    $finish;
  end

  task automatic verify(input logic ok, input string what);
    assert (ok) else begin
      $display("Error at %0d ns: %s", $time, what);
      errors++;
    end
  endtask

  function automatic int next_delay();
    return int'($unsigned($random(seed)) % 6);
  endfunction

  task automatic random_line(output coherence_pkg::line_t line);
    for (int i = 0; i < `COH_LINE_BITS / 32; i++) begin
      line[i*32 +: 32] = $random(seed);
    end
  endtask

  function automatic coherence_pkg::addr_t line_addr(input int tag, input int set);
    return coherence_pkg::addr_t'((tag << TAG_SHIFT) | (set << `COH_OFFSET_BITS));
  endfunction

  function automatic coherence_pkg::req_msg_t req_msg(input coherence_pkg::addr_t addr,
                                                      input coherence_pkg::bus_tx_t tx,
                                                      input int src);
    return '{valid: 1'b1, source: coherence_pkg::node_t'(src), addr: addr, bus_tx: tx};
  endfunction

  function automatic coherence_pkg::resp_msg_t resp_msg(
    input int src, input int way, input int dest, input logic to_mem,
    input coherence_pkg::addr_t addr, input coherence_pkg::line_t data,
    input coherence_pkg::mem_msg_t kind
  );
    return '{valid: 1'b1, source: coherence_pkg::node_t'(src),
             way: coherence_pkg::way_idx_t'(way), destination: coherence_pkg::node_t'(dest),
             memory_flag: to_mem, addr: addr, data: data, mem_msg: kind};
  endfunction

  // Bus and CPU strobes drop back to idle, way vectors are kept
  task automatic idle_cycle();
    @(posedge clk);
    lookup       <= 1'b0;
    miss_read    <= 1'b0;
    req_bus_msg  <= '0;
    resp_bus_msg <= '0;
    @(negedge clk);
  endtask

  task automatic miss_lookup(input coherence_pkg::addr_t addr, input int way);
    @(posedge clk);
    fetch_addr  <= addr;
    victim_ways <= coherence_pkg::way_vec_t'(1 << way);
    hit_ways    <= '0;
    miss_read   <= 1'b1;
    lookup      <= 1'b1;
    @(negedge clk);
  endtask

  task automatic hit_lookup(input coherence_pkg::addr_t addr, input int way);
    @(posedge clk);
    fetch_addr <= addr;
    hit_ways   <= coherence_pkg::way_vec_t'(1 << way);
    miss_read  <= 1'b0;
    lookup     <= 1'b1;
    @(negedge clk);
  endtask

  task automatic send_resp(input coherence_pkg::resp_msg_t msg);
    @(posedge clk);
    resp_bus_msg <= msg;
    @(negedge clk);
  endtask

  // Another node puts a request on the bus that hits one of our ways
  task automatic snoop(input coherence_pkg::addr_t addr, input int way,
                       input coherence_pkg::bus_tx_t tx);
    coherence_pkg::line_t data;
    random_line(data);
    @(posedge clk);
    bus_rdata      <= data;
    snoop_hit_ways <= coherence_pkg::way_vec_t'(1 << way);
    req_bus_msg    <= req_msg(addr, tx, 1);
    @(negedge clk);
  endtask

  task automatic echo_req(input int delay);
    coherence_pkg::req_msg_t held;
    held = req_bus_tx;
    verify(req_bus_req, "no request-bus request to echo");
    repeat (delay) begin
      idle_cycle();
      verify(req_bus_req && req_bus_tx == held, "request-bus message changed before echo");
    end
    @(posedge clk);
    req_bus_msg <= held;
    @(negedge clk);
    idle_cycle();
    verify(!req_bus_req, "request-bus request still high one cycle after echo");
  endtask

  task automatic echo_resp(input int delay);
    coherence_pkg::resp_msg_t held;
    held = resp_bus_tx;
    verify(resp_bus_req, "no response-bus request to echo");
    repeat (delay) begin
      idle_cycle();
      verify(resp_bus_req && resp_bus_tx == held, "response-bus message changed before echo");
    end
    send_resp(held);
    idle_cycle();
    verify(!resp_bus_req, "response-bus request still high one cycle after echo");
  endtask

  task automatic issue_miss(input coherence_pkg::addr_t addr, input int way);
    miss_lookup(addr, way);
    idle_cycle();
    verify(req_bus_req && req_bus_tx == req_msg(addr, coherence_pkg::GETS, 0),
           "GetS with fetch_addr not issued one cycle after the miss");
    verify(!req_bus_busy, "busy high before the GetS echo");
  endtask

  task automatic finish_fill(input coherence_pkg::addr_t addr, input logic excl,
                             input int delay);
    coherence_pkg::line_t data;
    random_line(data);
    echo_req(delay);
    verify(req_bus_busy, "busy did not rise after the GetS echo");
    send_resp(resp_msg(MEM_NODE, 0, 0, 1'b0, addr, data,
                       excl ? coherence_pkg::EXCLUSIVE : coherence_pkg::DATA));
    idle_cycle();
    verify(fill_valid && fill_data == data, "fill_valid or fill_data wrong after response");
    verify(!req_bus_busy, "busy still high after the fill");
    idle_cycle();
    verify(!fill_valid, "fill_valid longer than one cycle");
  endtask

  task automatic load_line(input coherence_pkg::addr_t addr, input int way, input logic excl);
    issue_miss(addr, way);
    finish_fill(addr, excl, next_delay());
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors + i_dut.i_props.failures == test_start) begin
      $display("Test %0d %s: passed", tests_run, name);
    end else begin
      failed_tests++;
      $display("Test %0d %s: failed", tests_run, name);
    end
    test_start = errors + i_dut.i_props.failures;
  endtask

  initial begin
    seed           = 76;
    errors         = 0;
    tests_run      = 0;
    failed_tests   = 0;
    test_start     = 0;
    rst            = 1'b1;
    fetch_addr     = '0;
    miss_read      = 1'b0;
    lookup         = 1'b0;
    hit_ways       = '0;
    victim_ways    = '0;
    snoop_hit_ways = '0;
    bus_rdata      = '0;
    req_bus_msg    = '0;
    resp_bus_msg   = '0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);

    // Every line starts in I
    verify(!req_bus_req && !resp_bus_req && !req_bus_busy && !fill_valid && !hit_resp,
           "control outputs not low after reset");
    hit_lookup(line_addr(1, 1), 2);
    verify(!hit_resp, "hit on an invalid line");
    issue_miss(line_addr(1, 1), 2);
    end_test("reset_and_miss");

    finish_fill(line_addr(1, 1), 1'b0, next_delay());
    hit_lookup(line_addr(1, 1), 2);
    verify(hit_resp, "no hit after a shared fill");
    load_line(line_addr(2, 2), 1, 1'b1);
    hit_lookup(line_addr(2, 2), 1);
    verify(hit_resp, "no hit after an exclusive fill");
    end_test("fill");

    // E line supplies data to a reader and keeps a shared copy
    snoop(line_addr(2, 2), 1, coherence_pkg::GETS);
    idle_cycle();
    verify(resp_bus_req && resp_bus_tx == resp_msg(0, 1, 1, 1'b1, line_addr(2, 2), bus_rdata,
                                                    coherence_pkg::DATA),
           "wrong response to another node's GetS");
    verify(req_bus_busy, "busy did not rise while supplying data");
    echo_resp(next_delay());
    verify(!req_bus_busy, "busy still high after the data echo");
    snoop(line_addr(2, 2), 1, coherence_pkg::GETM);
    idle_cycle();
    verify(!resp_bus_req, "S line answered a GetM");
    hit_lookup(line_addr(2, 2), 1);
    verify(!hit_resp, "hit after the line was invalidated");
    load_line(line_addr(3, 3), 3, 1'b1);
    snoop(line_addr(3, 3), 3, coherence_pkg::GETM);
    idle_cycle();
    verify(resp_bus_req && resp_bus_tx == resp_msg(0, 3, 1, 1'b0, line_addr(3, 3), bus_rdata,
                                                    coherence_pkg::DATA),
           "wrong response to another node's GetM");
    echo_resp(next_delay());
    end_test("snoop");

    load_line(line_addr(1, 4), 0, 1'b1);
    miss_lookup(line_addr(2, 4), 0);
    idle_cycle();
    verify(req_bus_req && req_bus_tx == req_msg(line_addr(2, 4), coherence_pkg::PUTM, 0),
           "PutM not issued when evicting an E line");
    hit_lookup(line_addr(1, 4), 0);
    verify(hit_resp, "no hit on a line waiting for its PutM");
    echo_req(next_delay());
    verify(resp_bus_req &&
           resp_bus_tx == resp_msg(0, 0, MEM_NODE, 1'b1, line_addr(2, 4), bus_rdata,
                                   coherence_pkg::NODATAE),
           "wrong release response after the PutM echo");
    echo_resp(next_delay());
    load_line(line_addr(1, 5), 2, 1'b0);
    miss_lookup(line_addr(2, 5), 2);
    idle_cycle();
    verify(!req_bus_req && !resp_bus_req, "bus traffic when evicting an S line");
    hit_lookup(line_addr(1, 5), 2);
    verify(!hit_resp, "hit on an evicted S line");
    end_test("evict");

    // Longest echo wait on both buses
    issue_miss(line_addr(1, 6), 1);
    finish_fill(line_addr(1, 6), 1'b1, 5);
    snoop(line_addr(1, 6), 1, coherence_pkg::GETS);
    idle_cycle();
    verify(resp_bus_req, "no response to a GetS on an E line");
    echo_resp(5);
    end_test("held_echo");

    $display("Tests run: %0d, failed: %0d, check errors: %0d, assertion failures: %0d",
             tests_run, failed_tests, errors, i_dut.i_props.failures);
    if (failed_tests == 0 && errors == 0 && i_dut.i_props.failures == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== icache_coherence_props.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "coherence_settings.svh"

module icache_coherence_props (
  input logic                     clk,
  input logic                     rst,
  input coherence_pkg::req_msg_t  req_bus_msg,
  input coherence_pkg::req_msg_t  req_bus_tx,
  input logic                     req_bus_req,
  input logic                     req_bus_busy,
  input coherence_pkg::resp_msg_t resp_bus_msg,
  input coherence_pkg::resp_msg_t resp_bus_tx,
  input logic                     resp_bus_req,
  input logic                     fill_valid,
  input logic                     hit_resp
);

  // Number of assertion failures so far
  int failures = 0;

  // A pending request stays frozen until its echo
  req_hold: assert property (@(posedge clk) disable iff (rst)
    req_bus_req && req_bus_msg != req_bus_tx |=> req_bus_req && $stable(req_bus_tx))
    else begin
      failures = failures + 1;
      $error("request bus message changed or dropped before its echo");
    end

  req_drop: assert property (@(posedge clk) disable iff (rst)
    req_bus_req && req_bus_msg == req_bus_tx |=> !req_bus_req)
    else begin
      failures = failures + 1;
      $error("request bus request still high after its echo");
    end

  resp_hold: assert property (@(posedge clk) disable iff (rst)
    resp_bus_req && resp_bus_msg != resp_bus_tx |=> resp_bus_req && $stable(resp_bus_tx))
    else begin
      failures = failures + 1;
      $error("response bus message changed or dropped before its echo");
    end

  // The response slot cannot reload on a cycle without a request-bus event
  resp_drop: assert property (@(posedge clk) disable iff (rst)
    resp_bus_req && resp_bus_msg == resp_bus_tx && !req_bus_msg.valid |=> !resp_bus_req)
    else begin
      failures = failures + 1;
      $error("response bus request still high after its echo");
    end

  fill_pulse: assert property (@(posedge clk) disable iff (rst)
    fill_valid |=> !fill_valid)
    else begin
      failures = failures + 1;
      $error("fill_valid lasted more than one cycle");
    end

  // Writeback release always goes to memory
  release_to_mem: assert property (@(posedge clk) disable iff (rst)
    resp_bus_req && resp_bus_tx.mem_msg == coherence_pkg::NODATAE |->
      resp_bus_tx.destination == coherence_pkg::node_t'(`COH_NUM_NODES) &&
      resp_bus_tx.memory_flag)
    else begin
      failures = failures + 1;
      $error("NODATAE response not addressed to memory");
    end

  quiet_after_reset: assert property (@(posedge clk)
    rst |=> !req_bus_req && !resp_bus_req && !req_bus_busy && !fill_valid && !hit_resp)
    else begin
      failures = failures + 1;
      $error("outputs not quiet after reset");
    end

endmodule

`default_nettype wire

// ==== icache_coherence.sv ====
`timescale 1ns/100ps
`default_nettype none

module icache_coherence #(
  parameter int ID = 0
) (
  input  logic                     clk,
  input  logic                     rst,

  // CPU side
  input  coherence_pkg::addr_t     fetch_addr,
  input  logic                     miss_read,
  input  logic                     lookup,
  input  coherence_pkg::way_vec_t  hit_ways,
  input  coherence_pkg::way_vec_t  victim_ways,
  input  coherence_pkg::way_vec_t  snoop_hit_ways,
  input  coherence_pkg::line_t     bus_rdata,
  output logic                     hit_resp,
  output coherence_pkg::line_t     fill_data,
  output logic                     fill_valid,

  // Request bus
  input  coherence_pkg::req_msg_t  req_bus_msg,
  output coherence_pkg::req_msg_t  req_bus_tx,
  output logic                     req_bus_req,
  output logic                     req_bus_busy,

  // Response bus
  input  coherence_pkg::resp_msg_t resp_bus_msg,
  output coherence_pkg::resp_msg_t resp_bus_tx,
  output logic                     resp_bus_req
);

  coherence_pkg::set_idx_t    cpu_index;
  coherence_pkg::set_idx_t    req_index;
  coherence_pkg::set_idx_t    resp_index;
  coherence_pkg::set_idx_t    write_index;
  coherence_pkg::way_states_t cpu_state;
  coherence_pkg::way_states_t req_state;
  coherence_pkg::way_states_t resp_state;
  coherence_pkg::way_states_t next_state;
  coherence_pkg::way_vec_t    write_ways;
  logic                       req_load;
  coherence_pkg::req_msg_t    req_payload;
  logic                       resp_load;
  coherence_pkg::resp_msg_t   resp_payload;

  line_state_table i_table (
    .clk         (clk),
    .rst         (rst),
    .cpu_index   (cpu_index),
    .req_index   (req_index),
    .resp_index  (resp_index),
    .cpu_state   (cpu_state),
    .req_state   (req_state),
    .resp_state  (resp_state),
    .next_state  (next_state),
    .write_ways  (write_ways),
    .write_index (write_index)
  );

  coherence_ctrl #(
    .ID (ID)
  ) i_ctrl (
    .clk            (clk),
    .rst            (rst),
    .fetch_addr     (fetch_addr),
    .miss_read      (miss_read),
    .lookup         (lookup),
    .hit_ways       (hit_ways),
    .victim_ways    (victim_ways),
    .snoop_hit_ways (snoop_hit_ways),
    .bus_rdata      (bus_rdata),
    .req_bus_msg    (req_bus_msg),
    .resp_bus_msg   (resp_bus_msg),
    .cpu_index      (cpu_index),
    .req_index      (req_index),
    .resp_index     (resp_index),
    .cpu_state      (cpu_state),
    .req_state      (req_state),
    .resp_state     (resp_state),
    .next_state     (next_state),
    .write_ways     (write_ways),
    .write_index    (write_index),
    .hit_resp       (hit_resp),
    .fill_data      (fill_data),
    .fill_valid     (fill_valid),
    .req_bus_busy   (req_bus_busy),
    .req_load       (req_load),
    .req_payload    (req_payload),
    .resp_load      (resp_load),
    .resp_payload   (resp_payload)
  );

  // Each bus gets its own issue slot
  bus_issue_slot #(
    .payload_t (coherence_pkg::req_msg_t)
  ) req_slot (
    .clk      (clk),
    .rst      (rst),
    .load     (req_load),
    .payload  (req_payload),
    .observed (req_bus_msg),
    .req      (req_bus_req),
    .tx       (req_bus_tx)
  );

  bus_issue_slot #(
    .payload_t (coherence_pkg::resp_msg_t)
  ) resp_slot (
    .clk      (clk),
    .rst      (rst),
    .load     (resp_load),
    .payload  (resp_payload),
    .observed (resp_bus_msg),
    .req      (resp_bus_req),
    .tx       (resp_bus_tx)
  );

endmodule

`default_nettype wire

// ==== bus_issue_slot.sv ====
`timescale 1ns/100ps
`default_nettype none

module bus_issue_slot #(
  parameter type payload_t = logic [0:0]
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     load,
  input  payload_t payload,
  input  payload_t observed,
  output logic     req,
  output payload_t tx
);

  logic echo;

  // Our message has won the bus once it shows up unchanged
  assign echo = req && (observed == tx);

  // A pending message stays frozen until its echo
  // A new load is taken when the slot is idle or is just freeing up
  always_ff @(posedge clk) begin
    if (rst) begin
      req <= 1'b0;
      tx  <= '0;
    end else if (load && (!req || echo)) begin
      req <= 1'b1;
      tx  <= payload;
    end else if (echo) begin
      req <= 1'b0;
      tx  <= '0;
    end
  end

endmodule

`default_nettype wire

// ==== coherence_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "coherence_settings.svh"

module coherence_ctrl #(
  parameter int ID = 0
) (
  input  logic                       clk,
  input  logic                       rst,
  input  coherence_pkg::addr_t       fetch_addr,
  input  logic                       miss_read,
  input  logic                       lookup,
  input  coherence_pkg::way_vec_t    hit_ways,
  input  coherence_pkg::way_vec_t    victim_ways,
  input  coherence_pkg::way_vec_t    snoop_hit_ways,
  input  coherence_pkg::line_t       bus_rdata,
  input  coherence_pkg::req_msg_t    req_bus_msg,
  input  coherence_pkg::resp_msg_t   resp_bus_msg,
  output coherence_pkg::set_idx_t    cpu_index,
  output coherence_pkg::set_idx_t    req_index,
  output coherence_pkg::set_idx_t    resp_index,
  input  coherence_pkg::way_states_t cpu_state,
  input  coherence_pkg::way_states_t req_state,
  input  coherence_pkg::way_states_t resp_state,
  output coherence_pkg::way_states_t next_state,
  output coherence_pkg::way_vec_t    write_ways,
  output coherence_pkg::set_idx_t    write_index,
  output logic                       hit_resp,
  output coherence_pkg::line_t       fill_data,
  output logic                       fill_valid,
  output logic                       req_bus_busy,
  output logic                       req_load,
  output coherence_pkg::req_msg_t    req_payload,
  output logic                       resp_load,
  output coherence_pkg::resp_msg_t   resp_payload
);

  localparam coherence_pkg::node_t OWN_NODE = coherence_pkg::node_t'(ID);
  localparam coherence_pkg::node_t MEM_NODE = coherence_pkg::node_t'(`COH_NUM_NODES);

  coherence_pkg::way_states_t ev_state;
  logic req_ev;
  logic resp_ev;
  logic cpu_ev;
  logic own_req;
  logic snoop_get;
  logic snoop_to_mem;
  logic own_echo;
  logic fill_ok;
  logic busy_next;
  logic fill_next;

  // Set index sits just above the line offset
  assign cpu_index  = fetch_addr[`COH_OFFSET_BITS +: `COH_INDEX_BITS];
  assign req_index  = req_bus_msg.addr[`COH_OFFSET_BITS +: `COH_INDEX_BITS];
  assign resp_index = resp_bus_msg.addr[`COH_OFFSET_BITS +: `COH_INDEX_BITS];

  // Request bus beats response bus, which beats the CPU
  assign req_ev  = req_bus_msg.valid;
  assign resp_ev = !req_bus_msg.valid && resp_bus_msg.valid;
  assign cpu_ev  = !req_bus_msg.valid && !resp_bus_msg.valid && lookup;

  assign own_req      = req_bus_msg.source == OWN_NODE;
  assign snoop_get    = !own_req && (req_bus_msg.bus_tx == coherence_pkg::GETS ||
                                     req_bus_msg.bus_tx == coherence_pkg::GETM);
  // Memory also takes the line when another cache only reads it
  assign snoop_to_mem = req_bus_msg.bus_tx == coherence_pkg::GETS;
  assign own_echo     = resp_bus_msg.source == OWN_NODE;
  assign fill_ok      = resp_bus_msg.destination == OWN_NODE &&
                        (resp_bus_msg.mem_msg == coherence_pkg::DATA ||
                         resp_bus_msg.mem_msg == coherence_pkg::EXCLUSIVE);

  function automatic coherence_pkg::resp_msg_t make_resp(
    input int                      way,
    input coherence_pkg::node_t    dest,
    input logic                    to_mem,
    input coherence_pkg::mem_msg_t msg
  );
    return '{valid: 1'b1, source: OWN_NODE, way: coherence_pkg::way_idx_t'(way),
             destination: dest, memory_flag: to_mem, addr: req_bus_msg.addr,
             data: bus_rdata, mem_msg: msg};
  endfunction

  always_comb begin
    busy_next    = req_bus_busy;
    fill_next    = 1'b0;
    req_load     = 1'b0;
    req_payload  = '0;
    resp_load    = 1'b0;
    resp_payload = '0;
    if (req_ev) begin
      ev_state    = req_state;
      write_index = req_index;
    end else if (resp_ev) begin
      ev_state    = resp_state;
      write_index = resp_index;
    end else begin
      ev_state    = cpu_state;
      write_index = cpu_index;
    end
    next_state = ev_state;

    for (int i = 0; i < `COH_WAYS; i++) begin
      if (req_ev) begin
        case (ev_state[i])
          coherence_pkg::ISAD: begin
            if (own_req && req_bus_msg.bus_tx == coherence_pkg::GETS && victim_ways[i]) begin
              next_state[i] = coherence_pkg::ISD;
              busy_next     = 1'b1;
            end
          end
          coherence_pkg::S: begin
            if (snoop_get && !snoop_to_mem && snoop_hit_ways[i]) begin
              next_state[i] = coherence_pkg::I;
            end
          end
          coherence_pkg::E: begin
            if (snoop_get && snoop_hit_ways[i]) begin
              next_state[i] = snoop_to_mem ? coherence_pkg::SRD : coherence_pkg::IRD;
              busy_next     = 1'b1;
              resp_load     = 1'b1;
              resp_payload  = make_resp(i, req_bus_msg.source, snoop_to_mem, coherence_pkg::DATA);
            end
          end
          coherence_pkg::EIA: begin
            if (own_req && req_bus_msg.bus_tx == coherence_pkg::PUTM && victim_ways[i]) begin
              next_state[i] = coherence_pkg::I;
              resp_load     = 1'b1;
              resp_payload  = make_resp(i, MEM_NODE, 1'b1, coherence_pkg::NODATAE);
            end else if (snoop_get && snoop_hit_ways[i]) begin
              next_state[i] = coherence_pkg::IIARD;
              busy_next     = 1'b1;
              resp_load     = 1'b1;
              resp_payload  = make_resp(i, req_bus_msg.source, snoop_to_mem, coherence_pkg::DATA);
            end
          end
          coherence_pkg::IIA: begin
            // Data already went out, memory only needs the release
            if (own_req && req_bus_msg.bus_tx == coherence_pkg::PUTM && victim_ways[i]) begin
              next_state[i] = coherence_pkg::I;
              resp_load     = 1'b1;
              resp_payload  = make_resp(i, MEM_NODE, 1'b1, coherence_pkg::NODATA);
            end
          end
          default: begin
          end
        endcase
      end else if (resp_ev) begin
        case (ev_state[i])
          coherence_pkg::ISD: begin
            if (fill_ok && victim_ways[i]) begin
              next_state[i] = resp_bus_msg.mem_msg == coherence_pkg::EXCLUSIVE ?
                              coherence_pkg::E : coherence_pkg::S;
              fill_next     = 1'b1;
              busy_next     = 1'b0;
            end
          end
          coherence_pkg::SRD: begin
            if (own_echo && resp_bus_msg.way == coherence_pkg::way_idx_t'(i)) begin
              next_state[i] = coherence_pkg::S;
              busy_next     = 1'b0;
            end
          end
          coherence_pkg::IRD: begin
            if (own_echo && resp_bus_msg.way == coherence_pkg::way_idx_t'(i)) begin
              next_state[i] = coherence_pkg::I;
              busy_next     = 1'b0;
            end
          end
          coherence_pkg::IIARD: begin
            if (own_echo && resp_bus_msg.way == coherence_pkg::way_idx_t'(i)) begin
              next_state[i] = coherence_pkg::IIA;
              busy_next     = 1'b0;
            end
          end
          default: begin
          end
        endcase
      end else if (cpu_ev && miss_read && victim_ways[i]) begin
        case (ev_state[i])
          coherence_pkg::I: begin
            next_state[i] = coherence_pkg::ISAD;
            req_load      = 1'b1;
            req_payload   = '{valid: 1'b1, source: OWN_NODE, addr: fetch_addr,
                              bus_tx: coherence_pkg::GETS};
          end
          coherence_pkg::S: begin
            next_state[i] = coherence_pkg::I;
          end
          coherence_pkg::E: begin
            next_state[i] = coherence_pkg::EIA;
            req_load      = 1'b1;
            req_payload   = '{valid: 1'b1, source: OWN_NODE, addr: fetch_addr,
                              bus_tx: coherence_pkg::PUTM};
          end
          default: begin
          end
        endcase
      end
    end

    // Only ways whose state moves get written back
    for (int i = 0; i < `COH_WAYS; i++) begin
      write_ways[i] = next_state[i] != ev_state[i];
    end
  end

  // Readable states answer a fetch in the same cycle
  always_comb begin
    hit_resp = 1'b0;
    for (int i = 0; i < `COH_WAYS; i++) begin
      if (lookup && hit_ways[i] &&
          cpu_state[i] inside {coherence_pkg::S, coherence_pkg::E, coherence_pkg::EIA}) begin
        hit_resp = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      req_bus_busy <= 1'b0;
      fill_valid   <= 1'b0;
    end else begin
      req_bus_busy <= busy_next;
      fill_valid   <= fill_next;
    end
  end

  always_ff @(posedge clk) begin
    if (fill_next) begin
      fill_data <= resp_bus_msg.data;
    end
  end

endmodule

`default_nettype wire

// ==== line_state_table.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "coherence_settings.svh"

module line_state_table (
  input  logic                       clk,
  input  logic                       rst,
  input  coherence_pkg::set_idx_t    cpu_index,
  input  coherence_pkg::set_idx_t    req_index,
  input  coherence_pkg::set_idx_t    resp_index,
  output coherence_pkg::way_states_t cpu_state,
  output coherence_pkg::way_states_t req_state,
  output coherence_pkg::way_states_t resp_state,
  input  coherence_pkg::way_states_t next_state,
  input  coherence_pkg::way_vec_t    write_ways,
  input  coherence_pkg::set_idx_t    write_index
);

  coherence_pkg::line_state_t state_mem [`COH_WAYS][`COH_SETS];

  // Every line starts invalid
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int w = 0; w < `COH_WAYS; w++) begin
        for (int s = 0; s < `COH_SETS; s++) begin
          state_mem[w][s] <= coherence_pkg::I;
        end
      end
    end else begin
      for (int w = 0; w < `COH_WAYS; w++) begin
        if (write_ways[w]) begin
          state_mem[w][write_index] <= next_state[w];
        end
      end
    end
  end

  // Three independent read ports, one per event source
  always_comb begin
    for (int w = 0; w < `COH_WAYS; w++) begin
      cpu_state[w]  = state_mem[w][cpu_index];
      req_state[w]  = state_mem[w][req_index];
      resp_state[w] = state_mem[w][resp_index];
    end
  end

endmodule

`default_nettype wire

// ==== coherence_pkg.sv ====
`default_nettype none
`include "coherence_settings.svh"

package coherence_pkg;

  // Stable and transient line states of the read-only protocol
  typedef enum logic [3:0] {
    I,
    ISAD,
    ISD,
    S,
    E,
    SRD,
    IRD,
    EIA,
    IIA,
    IIARD
  } line_state_t;

  // Request bus transactions
  typedef enum logic [1:0] {
    NONE,
    GETS,
    GETM,
    PUTM
  } bus_tx_t;

  // Response bus message kinds
  typedef enum logic [1:0] {
    DATA,
    EXCLUSIVE,
    NODATA,
    NODATAE
  } mem_msg_t;

  typedef logic [`COH_ADDR_BITS-1:0]  addr_t;
  typedef logic [`COH_LINE_BITS-1:0]  line_t;
  typedef logic [`COH_NODE_BITS-1:0]  node_t;
  typedef logic [`COH_WAY_BITS-1:0]   way_idx_t;
  typedef logic [`COH_INDEX_BITS-1:0] set_idx_t;
  typedef logic [`COH_WAYS-1:0]       way_vec_t;

  // One state per way at a single set index
  typedef line_state_t [`COH_WAYS-1:0] way_states_t;

  typedef struct packed {
    logic    valid;
    node_t   source;
    addr_t   addr;
    bus_tx_t bus_tx;
  } req_msg_t;

  typedef struct packed {
    logic     valid;
    node_t    source;
    way_idx_t way;
    node_t    destination;
    logic     memory_flag;
    addr_t    addr;
    line_t    data;
    mem_msg_t mem_msg;
  } resp_msg_t;

endpackage

`default_nettype wire

// ==== coherence_settings.svh ====
`ifndef COHERENCE_SETTINGS_SVH
`define COHERENCE_SETTINGS_SVH

// Physical address width
`define COH_ADDR_BITS 32

// Line geometry
`define COH_LINE_BYTES 32
`define COH_LINE_BITS 256

// Cache organization
`define COH_WAYS 4
`define COH_SETS 16

// Derived field widths
`define COH_OFFSET_BITS $clog2(`COH_LINE_BYTES)
`define COH_INDEX_BITS $clog2(`COH_SETS)
`define COH_WAY_BITS $clog2(`COH_WAYS)

// Node numbering on the bus
// Caches are 0 to COH_NUM_NODES-1 and memory answers as COH_NUM_NODES
`define COH_NODE_BITS 2
`define COH_NUM_NODES 3

`endif
